//--- files.f
+incdir+include
+incdir+dv
design/debug_display_pkg.sv
design/probe_latch.sv
design/scan_timer.sv
design/scan_fsm.sv
design/digit_extractor.sv
design/hex_display_bank.sv
design/debug_display_top.sv
dv/debug_display_tb.sv

//--- Bender.yml
package:
  name: debug_display

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/debug_display_pkg.sv
      - design/probe_latch.sv
      - design/scan_timer.sv
      - design/scan_fsm.sv
      - design/digit_extractor.sv
      - design/hex_display_bank.sv
      - design/debug_display_top.sv
  - target: test
    include_dirs:
      - include
      - dv
    files:
      - dv/debug_display_tb.sv

//--- dv/debug_display_checks.svh
`ifndef DEBUG_DISPLAY_CHECKS_SVH
`define DEBUG_DISPLAY_CHECKS_SVH

// first failure ends the run
task automatic abort_run();
  $display("Errors found");
  $fatal(1, "simulation stopped at the first failed check");
endtask

task automatic check_hex(input int idx, input logic [6:0] exp_seg, input logic [6:0] act_seg);
  if (act_seg !== exp_seg) begin
    $display("ERR t=%0t hex[%0d] expected %b actual %b", $time, idx, exp_seg, act_seg);
    abort_run();
  end
endtask

task automatic check_ledr(input logic [9:0] exp_led, input logic [9:0] act_led);
  if (act_led !== exp_led) begin
    $display("ERR t=%0t ledr expected %b actual %b", $time, exp_led, act_led);
    abort_run();
  end
endtask

// whole board state against one expected picture
function automatic logic display_matches(input disp_t e);
  logic ok;
  ok = (ledr === e.ledr);
  for (int i = 0; i < `DD_NUM_DIGITS; i++) begin
    if (hex[i] !== e.hex[i]) begin
      ok = 1'b0;
    end
  end
  return ok;
endfunction

// stimulus side waits here until the checker has handled the request
task automatic wait_checked();
  int cycles;
  cycles = 0;
  while (checks_done != checks_asked && cycles < SETTLE_CYCLES + 8) begin
    @(posedge clk);
    cycles++;
  end
  if (checks_done != checks_asked) begin
    $display("checker gave no verdict within %0d cycles", cycles);
    abort_run();
  end
endtask

`endif

//--- dv/debug_display_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_display_consts.svh"

module debug_display_tb import debug_display_pkg::*; ();

  localparam int SETTLE_CYCLES = 14 * `DD_STEP_CYCLES;  // finish the old scan and run a new one
  localparam logic [6:0] SEG_TABLE [10] = '{
    `DD_SEG_0, `DD_SEG_1, `DD_SEG_2, `DD_SEG_3, `DD_SEG_4,
    `DD_SEG_5, `DD_SEG_6, `DD_SEG_7, `DD_SEG_8, `DD_SEG_9
  };

  typedef struct packed {
    logic [`DD_NUM_DIGITS-1:0][6:0] hex;
    logic [9:0]                     ledr;
  } disp_t;

  logic         clk;
  logic         rst_n;
  stage_probe_t stages [`DD_NUM_STAGES];
  core_regs_t   core_regs;
  logic [9:0]   sw;
  logic [6:0]   hex [`DD_NUM_DIGITS];
  logic [9:0]   ledr;

  stage_probe_t [`DD_NUM_STAGES-1:0] cur_stages;
  core_regs_t   cur_regs;
  sw_cfg_t      cur_sw;
  disp_t        exp_disp;
  int           settle_cnt = 0;
  int           checks_asked = 0;
  int           checks_done = 0;
  logic [31:0]  lfsr_state = 32'd78607;

  `include "debug_display_checks.svh"

  debug_display_top u_debug_display_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .stages    (stages),
    .core_regs (core_regs),
    .sw        (sw),
    .hex       (hex),
    .ledr      (ledr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic disp_t expected_display(input stage_probe_t [`DD_NUM_STAGES-1:0] st,
                                             input core_regs_t regs, input sw_cfg_t s);
    disp_t        d;
    stage_probe_t slot;
    int unsigned  value;
    int           dig;
    d.ledr = '0;
    for (int i = 0; i < `DD_NUM_DIGITS; i++) begin
      d.hex[i] = `DD_SEG_BLANK;
    end
    if (!s.show_enable) begin
      return d;
    end
    slot.pc     = pc_t'(`DD_IDLE_PC);  // select 7
    slot.opcode = '0;
    if (s.stage_sel < `DD_NUM_STAGES) begin
      slot = st[s.stage_sel];
    end
    value = s.reg_mode ? int'(regs.sel_reg[19:0]) % 1000000 : int'(slot.pc);
    for (int i = 0; i < `DD_NUM_DIGITS; i++) begin
      if (!s.reg_mode && s.view_sel == 5'b10000) begin
        dig = (i < 4) ? int'(regs.status[28 + i]) : 0;
      end else begin
        dig   = value % 10;
        value = value / 10;
      end
      d.hex[i] = SEG_TABLE[dig];
    end
    if (!s.reg_mode) begin
      d.ledr = {3'b000, slot.opcode};
    end
    return d;
  endfunction

  function automatic sw_cfg_t pc_view(input logic [2:0] sel);
    sw_cfg_t s;
    s.show_enable = 1'b1;
    s.reg_mode    = 1'b0;
    s.view_sel    = 5'(rand_bits(5));
    s.stage_sel   = sel;
    if (s.view_sel == 5'b10000) begin
      s.view_sel = 5'b00000;  // keep out of status mode
    end
    return s;
  endfunction

  function automatic void random_view();
    logic [1:0] kind;
    kind   = 2'(rand_bits(2));
    cur_sw = pc_view(3'(rand_bits(3)));
    if (kind == 2'd1) begin
      cur_sw.reg_mode = 1'b1;
    end else if (kind == 2'd2) begin
      cur_sw.view_sel = 5'b10000;
    end
  endfunction

  function automatic void rand_probes();
    for (int i = 0; i < `DD_NUM_STAGES; i++) begin
      cur_stages[i].pc     = pc_t'(rand_bits(7));
      cur_stages[i].opcode = opcode_t'(rand_bits(7));
    end
    cur_regs.sel_reg = rand_bits(32);
    cur_regs.status  = rand_bits(32);
  endfunction

  task automatic apply_inputs();
    @(posedge clk);
    for (int i = 0; i < `DD_NUM_STAGES; i++) begin
      stages[i] <= cur_stages[i];
    end
    core_regs <= cur_regs;
    sw        <= cur_sw;
  endtask

  task automatic apply_and_check();
    apply_inputs();
    exp_disp = expected_display(cur_stages, cur_regs, cur_sw);
    checks_asked++;
    wait_checked();
  endtask

  // compares at the falling edge, once the display matches or the bound runs out
  always @(negedge clk) begin
    if (checks_done != checks_asked) begin
      if (display_matches(exp_disp) || settle_cnt >= SETTLE_CYCLES) begin
        if (!display_matches(exp_disp)) begin
          $display("display did not settle within %0d cycles", SETTLE_CYCLES);
        end
        for (int i = 0; i < `DD_NUM_DIGITS; i++) begin
          check_hex(i, exp_disp.hex[i], hex[i]);
        end
        check_ledr(exp_disp.ledr, ledr);
        settle_cnt = 0;
        checks_done++;
      end else begin
        settle_cnt++;
      end
    end
  end

  initial begin
    int gap;
    rst_n     = 1'b0;
    sw        = '0;
    core_regs = '0;
    for (int i = 0; i < `DD_NUM_STAGES; i++) begin
      stages[i] = '0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    for (int n = 0; n < 4; n++) begin  // display off
      rand_probes();
      cur_sw = sw_cfg_t'(rand_bits(10));
      cur_sw.show_enable = 1'b0;
      apply_and_check();
    end
    for (int s = 0; s < 8; s++) begin  // every stage select including the idle select 7
      rand_probes();
      cur_sw = pc_view(3'(s));
      apply_and_check();
    end
    for (int n = 0; n < 8; n++) begin
      rand_probes();
      cur_sw = pc_view(3'(rand_bits(3)));
      cur_sw.reg_mode = 1'b1;
      apply_and_check();
    end
    for (int n = 0; n < 8; n++) begin
      rand_probes();
      cur_sw = pc_view(3'(rand_bits(3)));
      cur_sw.view_sel = 5'b10000;
      apply_and_check();
    end

    // switches move again while a scan is running
    for (int n = 0; n < 6; n++) begin
      rand_probes();
      random_view();
      apply_inputs();
      gap = int'(rand_bits(4)) + 2;
      repeat (gap) @(posedge clk);
      random_view();
      apply_and_check();
    end

    // core values change under fixed switches
    for (int v = 0; v < 3; v++) begin
      random_view();
      apply_and_check();
      for (int n = 0; n < 3; n++) begin
        rand_probes();
        apply_and_check();
      end
    end

    $display("No errors");
    $finish;
  end

endmodule : debug_display_tb

`default_nettype wire

//--- design/debug_display_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_display_consts.svh"

module debug_display_top import debug_display_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  stage_probe_t stages [`DD_NUM_STAGES],
  input  core_regs_t   core_regs,
  input  logic [9:0]   sw,
  output logic [6:0]   hex [`DD_NUM_DIGITS],
  output logic [9:0]   ledr
);

  // stage select 7 shows the idle pc with no opcode
  localparam stage_probe_t IDLE_STAGE = '{pc: pc_t'(`DD_IDLE_PC), opcode: opcode_t'(0)};

  sw_cfg_t      sw_cfg;
  logic         step;
  logic         load;
  logic         shift;
  logic         wr_en;
  digit_idx_t   wr_idx;
  view_mode_e   mode;
  stage_probe_t stage_sel;
  core_regs_t   regs_entries [1];
  core_regs_t   regs_sel;
  digit_t       digit;

  assign sw_cfg          = sw_cfg_t'(sw);
  assign regs_entries[0] = core_regs;

  scan_timer u_scan_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .step  (step)
  );

  scan_fsm u_scan_fsm (
    .clk    (clk),
    .rst_n  (rst_n),
    .step   (step),
    .sw     (sw_cfg),
    .load   (load),
    .shift  (shift),
    .wr_en  (wr_en),
    .wr_idx (wr_idx),
    .mode   (mode)
  );

  probe_latch #(
    .payload_t  (stage_probe_t),
    .N_ENTRIES  (`DD_NUM_STAGES),
    .IDLE_VALUE (IDLE_STAGE)
  ) u_stage_latch (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .sel      (sw_cfg.stage_sel),
    .entries  (stages),
    .selected (stage_sel)
  );

  probe_latch #(
    .payload_t  (core_regs_t),
    .N_ENTRIES  (1),
    .IDLE_VALUE (core_regs_t'(0))
  ) u_regs_latch (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .sel      (3'd0),
    .entries  (regs_entries),
    .selected (regs_sel)
  );

  digit_extractor u_digit_extractor (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .shift (shift),
    .mode  (mode),
    .pc    (stage_sel.pc),
    .regs  (regs_sel),
    .digit (digit)
  );

  hex_display_bank u_hex_display_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .wr_idx      (wr_idx),
    .digit       (digit),
    .show_enable (sw_cfg.show_enable),
    .reg_mode    (sw_cfg.reg_mode),
    .opcode      (stage_sel.opcode),
    .hex         (hex),
    .ledr        (ledr)
  );

endmodule : debug_display_top

`default_nettype wire

//--- design/hex_display_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_display_consts.svh"

module hex_display_bank import debug_display_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr_en,
  input  digit_idx_t wr_idx,
  input  digit_t     digit,
  input  logic       show_enable,
  input  logic       reg_mode,
  input  opcode_t    opcode,
  output logic [6:0] hex [`DD_NUM_DIGITS],
  output logic [9:0] ledr
);

  logic [6:0] seg_q [`DD_NUM_DIGITS];

  function automatic logic [6:0] encode(digit_t d);
    case (d)
      4'd0:    return `DD_SEG_0;
      4'd1:    return `DD_SEG_1;
      4'd2:    return `DD_SEG_2;
      4'd3:    return `DD_SEG_3;
      4'd4:    return `DD_SEG_4;
      4'd5:    return `DD_SEG_5;
      4'd6:    return `DD_SEG_6;
      4'd7:    return `DD_SEG_7;
      4'd8:    return `DD_SEG_8;
      4'd9:    return `DD_SEG_9;
      default: return `DD_SEG_BLANK;
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `DD_NUM_DIGITS; i++) begin
        seg_q[i] <= `DD_SEG_BLANK;
      end
    end else if (wr_en) begin
      for (int i = 0; i < `DD_NUM_DIGITS; i++) begin
        if (wr_idx == digit_idx_t'(i)) begin
          seg_q[i] <= encode(digit);
        end
      end
    end
  end

  // blanking follows the enable switch directly
  always_comb begin
    for (int i = 0; i < `DD_NUM_DIGITS; i++) begin
      hex[i] = show_enable ? seg_q[i] : `DD_SEG_BLANK;
    end
  end

  assign ledr = (show_enable && !reg_mode) ? {3'b000, opcode} : 10'd0;

endmodule : hex_display_bank

`default_nettype wire

//--- design/digit_extractor.sv
`timescale 1ns/1ps
`default_nettype none

module digit_extractor import debug_display_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load,
  input  logic       shift,
  input  view_mode_e mode,
  input  pc_t        pc,
  input  core_regs_t regs,
  output digit_t     digit
);

  logic [19:0] value_q;
  logic [19:0] value_cur;
  logic [3:0]  stat_q;    // status bits 31..28, bit 28 at the bottom
  logic [3:0]  stat_cur;

  // value after this cycle's load or shift
  always_comb begin
    if (load) begin
      if (mode == view_reg) begin
        value_cur = regs.sel_reg[19:0];
      end else begin
        value_cur = {13'd0, pc};
      end
      stat_cur = regs.status[31:28];
    end else if (shift) begin
      value_cur = value_q / 20'd10;
      stat_cur  = {1'b0, stat_q[3:1]};
    end else begin
      value_cur = value_q;
      stat_cur  = stat_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value_q <= '0;
      stat_q  <= '0;
    end else if (load || shift) begin
      value_q <= value_cur;
      stat_q  <= stat_cur;
    end
  end

  always_comb begin
    if (mode == view_status) begin
      digit = {3'b000, stat_cur[0]};
    end else begin
      digit = digit_t'(value_cur % 20'd10);  // remainder fits in 4 bits
    end
  end

  a_digit_bcd: assert property (
    @(posedge clk) disable iff (!rst_n)
    (load || shift) |-> (digit < 4'd10)
  ) else $error("digit out of bcd range: %0d", digit);

endmodule : digit_extractor

`default_nettype wire

//--- design/scan_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_display_consts.svh"

module scan_fsm import debug_display_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       step,
  input  sw_cfg_t    sw,
  output logic       load,
  output logic       shift,
  output logic       wr_en,
  output digit_idx_t wr_idx,
  output view_mode_e mode
);

  // the load itself happens on the step taken in idle
  typedef enum logic [2:0] {
    st_idle,
    st_dig1,
    st_dig2,
    st_dig3,
    st_dig4,
    st_dig5
  } state_e;

  state_e     state;
  state_e     state_nxt;
  sw_cfg_t    sw_q;    // switches captured at the last load
  view_mode_e mode_q;
  logic       sw_changed;

  function automatic view_mode_e decode_mode(sw_cfg_t s);
    if (s.reg_mode) begin
      return view_reg;
    end
    if (s.view_sel == 5'b10000) begin
      return view_status;
    end
    return view_pc;
  endfunction

  assign sw_changed = (sw != sw_q);

  always_comb begin
    load      = 1'b0;
    shift     = 1'b0;
    wr_en     = step;  // every step writes one digit
    wr_idx    = '0;
    state_nxt = state;
    if (step) begin
      if (state == st_idle || sw_changed) begin
        load      = 1'b1;  // digit 0 comes from the fresh seed
        state_nxt = st_dig1;
      end else begin
        shift  = 1'b1;
        wr_idx = digit_idx_t'(state);
        if (state == st_dig5) begin
          state_nxt = st_idle;
        end else begin
          state_nxt = state_e'(state + 3'd1);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= st_idle;
      sw_q   <= '0;
      mode_q <= view_pc;
    end else begin
      state <= state_nxt;
      if (load) begin
        sw_q   <= sw;
        mode_q <= decode_mode(sw);
      end
    end
  end

  // new mode must already be visible while the extractor seeds
  assign mode = load ? decode_mode(sw) : mode_q;

  a_load_shift_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(load && shift)
  ) else $error("load and shift in the same cycle");

  a_wr_idx_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> (wr_idx < `DD_NUM_DIGITS)
  ) else $error("digit write beyond the last display");

endmodule : scan_fsm

`default_nettype wire

//--- design/scan_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_display_consts.svh"

module scan_timer (
  input  logic clk,
  input  logic rst_n,
  output logic step
);

  localparam int CNT_W = (`DD_STEP_CYCLES > 1) ? $clog2(`DD_STEP_CYCLES) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`DD_STEP_CYCLES - 1);

  logic [CNT_W-1:0] cnt_q;

  // free running and restarts at zero after reset release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (cnt_q == LAST) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign step = (cnt_q == LAST);  // last cycle of the period

endmodule : scan_timer

`default_nettype wire

//--- design/probe_latch.sv
`timescale 1ns/1ps
`default_nettype none

module probe_latch #(
  parameter type      payload_t  = logic [7:0],
  parameter int       N_ENTRIES  = 1,
  parameter payload_t IDLE_VALUE = '0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load,
  input  logic [2:0] sel,
  input  payload_t   entries [N_ENTRIES],
  output payload_t   selected
);

  payload_t picked;
  payload_t held_q;  // snapshot kept for the rest of the scan

  always_comb begin
    picked = IDLE_VALUE;  // select beyond the last entry
    for (int i = 0; i < N_ENTRIES; i++) begin
      if (sel == 3'(i)) begin
        picked = entries[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held_q <= IDLE_VALUE;
    end else if (load) begin
      held_q <= picked;
    end
  end

  // fresh sample passes through in the load cycle so the extractor seeds from it
  assign selected = load ? picked : held_q;

  // one consistent sample across the whole scan
  a_selected_frozen: assert property (
    @(posedge clk) disable iff (!rst_n)
    !load |-> $stable(selected)
  ) else $error("probe snapshot moved without a load");

endmodule : probe_latch

`default_nettype wire

//--- design/debug_display_pkg.sv
`default_nettype none

package debug_display_pkg;

  typedef logic [6:0] pc_t;
  typedef logic [6:0] opcode_t;
  typedef logic [3:0] digit_t;      // one bcd digit
  typedef logic [2:0] digit_idx_t;  // hex0 .. hex5

  // one pipeline slot as seen from the core
  typedef struct packed {
    pc_t     pc;
    opcode_t opcode;
  } stage_probe_t;

  typedef struct packed {
    logic [31:0] sel_reg;  // architectural register picked by the core
    logic [31:0] status;
  } core_regs_t;

  // field order follows SW[9:0]
  typedef struct packed {
    logic       show_enable;  // SW[9]
    logic       reg_mode;     // SW[8]
    logic [4:0] view_sel;     // SW[7:3]
    logic [2:0] stage_sel;    // SW[2:0]
  } sw_cfg_t;

  // what the digits show during one scan
  typedef enum logic [1:0] {
    view_pc,
    view_reg,
    view_status
  } view_mode_e;

endpackage : debug_display_pkg

`default_nettype wire

//--- include/debug_display_consts.svh
`ifndef DEBUG_DISPLAY_CONSTS_SVH
`define DEBUG_DISPLAY_CONSTS_SVH

// board geometry
`define DD_NUM_DIGITS 6
`define DD_NUM_STAGES 7

// pc shown for the unused stage select value
`define DD_IDLE_PC 32

// clock cycles per scan step
`define DD_STEP_CYCLES 4

// active low seven-segment patterns with segment g on bit 6
`define DD_SEG_BLANK 7'b1111111
`define DD_SEG_0 7'b1000000
`define DD_SEG_1 7'b1111001
`define DD_SEG_2 7'b0100100
`define DD_SEG_3 7'b0110000
`define DD_SEG_4 7'b0011001
`define DD_SEG_5 7'b0010010
`define DD_SEG_6 7'b0000010
`define DD_SEG_7 7'b1111000
`define DD_SEG_8 7'b0000000
`define DD_SEG_9 7'b0010000

`endif
